// File: hw/ice_pkg.sv
package ice_pkg;

	// One host or bus character
	typedef logic [7:0] char_t;

	// Reply character toward the arbiter
	// Bit 8 flags the tail of a reply
	typedef logic [8:0] tagged_char_t;

	// Register nodes on the shared bus
	localparam int num_nodes = 4;
	typedef logic [num_nodes-1:0] node_sel_t;
	typedef logic [$clog2(num_nodes)-1:0] node_idx_t;

	// Registers per node
	localparam int num_regs = 4;
	typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

	// Longest node reply is evt, len, ack, value
	localparam int reply_len = 4;
	typedef logic [$clog2(reply_len)-1:0] reply_ptr_t;

	// Command opcodes
	localparam char_t op_write = 8'h57;
	localparam char_t op_read = 8'h52;

	// Reply status bytes
	localparam char_t status_ack = 8'h41;
	localparam char_t status_nak = 8'h4E;

	// Address byte of a controller NAK frame
	localparam char_t nak_addr = 8'hFF;

	// Host frame parser
	typedef enum logic [2:0] {
		ctrl_addr,
		ctrl_evt,
		ctrl_len,
		ctrl_payload,
		ctrl_skip
	} ctrl_state_t;

	// Node command and reply sequencing
	typedef enum logic [1:0] {node_idle, node_collect, node_reply} node_state_t;

	// Reply arbiter
	typedef enum logic [1:0] {arb_idle, arb_prefix, arb_stream, arb_nak} arb_state_t;

endpackage

// File: hw/ice_bus_controller.sv
module ice_bus_controller import ice_pkg::*; (
	input logic clk,
	input logic reset,

	// Host character stream
	input char_t rx_char,
	input logic rx_char_valid,

	// Master bus toward all nodes
	output char_t ma_addr,
	output char_t ma_evt,
	output char_t ma_len,
	output char_t ma_data,
	output logic ma_data_valid,
	output logic ma_frame_valid,

	// Immediate NAK toward the arbiter
	output logic generate_nak,
	output char_t nak_evt
);

ctrl_state_t state;

// Payload bytes still expected in this frame
char_t remaining;

// Set with the last broadcast byte
// Frame valid drops on the following edge
logic frame_last;

// Address matches one of the nodes
logic addr_known;

assign addr_known = ma_addr < char_t'(num_nodes);

always_ff @(posedge clk) begin
	if (reset) begin
		state <= ctrl_addr;
		remaining <= '0;
		frame_last <= 1'b0;
		ma_frame_valid <= 1'b0;
		ma_data_valid <= 1'b0;
		generate_nak <= 1'b0;
	end else begin
		// Strobes last one cycle
		ma_data_valid <= 1'b0;
		generate_nak <= 1'b0;

		// Close out the frame after its final byte
		if (frame_last) begin
			ma_frame_valid <= 1'b0;
			frame_last <= 1'b0;
		end

		if (rx_char_valid) begin
			case (state)
				ctrl_addr: state <= ctrl_evt;
				ctrl_evt: state <= ctrl_len;
				ctrl_len: begin
					remaining <= rx_char;
					if (addr_known) begin
						ma_frame_valid <= 1'b1;
						// Empty frame is valid for a single cycle
						if (rx_char == '0) begin
							frame_last <= 1'b1;
							state <= ctrl_addr;
						end else begin
							state <= ctrl_payload;
						end
					end else begin
						// Nobody owns this address
						generate_nak <= 1'b1;
						state <= (rx_char == '0) ? ctrl_addr : ctrl_skip;
					end
				end
				ctrl_payload: begin
					ma_data_valid <= 1'b1;
					remaining <= remaining - 8'd1;
					if (remaining == 8'd1) begin
						frame_last <= 1'b1;
						state <= ctrl_addr;
					end
				end
				ctrl_skip: begin
					// Swallow payload of an unknown address
					remaining <= remaining - 8'd1;
					if (remaining == 8'd1)
						state <= ctrl_addr;
				end
				default: state <= ctrl_addr;
			endcase
		end
	end
end

// Header and data capture
// Header bytes stay put until the next frame overwrites them
always_ff @(posedge clk) begin
	if (rx_char_valid) begin
		case (state)
			ctrl_addr: ma_addr <= rx_char;
			ctrl_evt: ma_evt <= rx_char;
			ctrl_len: begin
				ma_len <= rx_char;
				// Event id travels with the NAK pulse
				nak_evt <= ma_evt;
			end
			ctrl_payload: ma_data <= rx_char;
			default: begin
			end
		endcase
	end
end

endmodule

// File: hw/register_node.sv
module register_node import ice_pkg::*; #(
	parameter int node_id = 0
) (
	input logic clk,
	input logic reset,

	// Master bus
	input char_t ma_addr,
	input char_t ma_evt,
	input char_t ma_len,
	input char_t ma_data,
	input logic ma_data_valid,
	input logic ma_frame_valid,

	// Reply handshake with the arbiter
	input logic sl_grant,
	input logic sl_next,
	output logic sl_request,
	output tagged_char_t sl_data
);

node_state_t state;

// Previous frame valid for edge detect
logic frame_valid_q;

// Payload byte position, stops at 3
logic [1:0] byte_cnt;

// Captured frame fields
char_t evt_q;
char_t len_q;
char_t op_q;
char_t idx_q;
char_t wdata_q;

// Register file
char_t regs [num_regs];

// Reply buffer and read pointer
char_t rbuf [reply_len];
reply_ptr_t rptr;
reply_ptr_t rlast;

logic frame_start;
logic frame_done;
logic take;
logic is_write;
logic is_read;
logic cmd_ok;
reg_idx_t reg_sel;

// Only a fresh frame starts a command
// A frame already in flight when the node frees up is ignored
assign frame_start = (state == node_idle) && ma_frame_valid && !frame_valid_q &&
	(ma_addr == char_t'(node_id));
assign frame_done = (state == node_collect) && !ma_frame_valid;
assign take = (state == node_reply) && sl_grant && sl_next;

// Command checks
assign is_write = (op_q == op_write);
assign is_read = (op_q == op_read);
assign cmd_ok = ((is_write && len_q == 8'd3) || (is_read && len_q == 8'd2)) &&
	(idx_q < char_t'(num_regs));
assign reg_sel = reg_idx_t'(idx_q);

// Current reply character, tail when the pointer hits the end
assign sl_data = {rptr == rlast, rbuf[rptr]};

always_ff @(posedge clk) begin
	if (reset) begin
		state <= node_idle;
		frame_valid_q <= 1'b0;
		byte_cnt <= '0;
		rptr <= '0;
		sl_request <= 1'b0;
		for (int k = 0; k < num_regs; k++)
			regs[k] <= '0;
	end else begin
		frame_valid_q <= ma_frame_valid;
		case (state)
			node_idle: begin
				if (frame_start) begin
					byte_cnt <= '0;
					state <= node_collect;
				end
			end
			node_collect: begin
				if (ma_data_valid && byte_cnt != 2'd3)
					byte_cnt <= byte_cnt + 2'd1;
				if (frame_done) begin
					// Commit the write, then raise the request
					if (cmd_ok && is_write)
						regs[reg_sel] <= wdata_q;
					rptr <= '0;
					sl_request <= 1'b1;
					state <= node_reply;
				end
			end
			node_reply: begin
				// Stall here until the arbiter takes each character
				if (take) begin
					if (rptr == rlast) begin
						sl_request <= 1'b0;
						state <= node_idle;
					end else begin
						rptr <= rptr + reply_ptr_t'(1);
					end
				end
			end
			default: state <= node_idle;
		endcase
	end
end

// Frame fields and reply assembly
always_ff @(posedge clk) begin
	if (frame_start) begin
		evt_q <= ma_evt;
		len_q <= ma_len;
	end
	// Opcode, index, data in arrival order
	if (state == node_collect && ma_data_valid) begin
		case (byte_cnt)
			2'd0: op_q <= ma_data;
			2'd1: idx_q <= ma_data;
			2'd2: wdata_q <= ma_data;
			default: begin
			end
		endcase
	end
	if (frame_done) begin
		rbuf[0] <= evt_q;
		rbuf[2] <= status_ack;
		rbuf[3] <= regs[reg_sel];
		if (!cmd_ok) begin
			rbuf[1] <= 8'd1;
			rbuf[2] <= status_nak;
			rlast <= reply_ptr_t'(2);
		end else if (is_read) begin
			// Ack plus register value
			rbuf[1] <= 8'd2;
			rlast <= reply_ptr_t'(3);
		end else begin
			rbuf[1] <= 8'd1;
			rlast <= reply_ptr_t'(2);
		end
	end
end

endmodule

// File: hw/response_arbiter.sv
module response_arbiter import ice_pkg::*; (
	input logic clk,
	input logic reset,

	// Node replies
	input node_sel_t sl_request,
	input tagged_char_t sl_data [num_nodes],
	output node_sel_t sl_grant,
	output node_sel_t sl_next,

	// Controller NAK
	input logic generate_nak,
	input char_t nak_evt,

	// Transmitter
	input logic tx_char_ready,
	output char_t tx_char,
	output logic tx_char_valid
);

arb_state_t state;

// Granted node and the one served before it
node_idx_t grant_idx;
node_idx_t last_idx;

// Round robin search result
node_idx_t rr_pick;
node_idx_t cand;
logic rr_found;

// Single pending NAK slot
logic nak_pending;
char_t nak_evt_q;
logic [1:0] nak_pos;

tagged_char_t cur_char;

assign cur_char = sl_data[grant_idx];

// Every non idle state has a character ready, so ready alone paces it
assign tx_char_valid = (state != arb_idle) && tx_char_ready;
assign sl_next = (state == arb_stream && tx_char_ready) ? sl_grant : '0;

// Search starts just past the last grant
always_comb begin
	rr_pick = last_idx;
	rr_found = 1'b0;
	cand = last_idx;
	for (int k = 1; k <= num_nodes; k++) begin
		cand = node_idx_t'((int'(last_idx) + k) % num_nodes);
		if (!rr_found && sl_request[cand]) begin
			rr_pick = cand;
			rr_found = 1'b1;
		end
	end
end

// Outgoing character per state
always_comb begin
	tx_char = '0;
	case (state)
		arb_prefix: tx_char = char_t'(grant_idx);
		arb_stream: tx_char = cur_char[7:0];
		arb_nak: begin
			case (nak_pos)
				2'd0: tx_char = nak_addr;
				2'd1: tx_char = nak_evt_q;
				default: tx_char = 8'h00;
			endcase
		end
		default: tx_char = '0;
	endcase
end

always_ff @(posedge clk) begin
	if (reset) begin
		state <= arb_idle;
		sl_grant <= '0;
		grant_idx <= '0;
		last_idx <= node_idx_t'(num_nodes - 1);
		nak_pending <= 1'b0;
		nak_pos <= '0;
	end else begin
		case (state)
			arb_idle: begin
				// NAK goes out ahead of any node
				if (nak_pending) begin
					nak_pos <= '0;
					state <= arb_nak;
				end else if (rr_found) begin
					grant_idx <= rr_pick;
					sl_grant <= node_sel_t'(1) << rr_pick;
					state <= arb_prefix;
				end
			end
			arb_prefix: begin
				if (tx_char_ready)
					state <= arb_stream;
			end
			arb_stream: begin
				// Grant held until the tail is taken
				if (tx_char_ready && cur_char[8]) begin
					sl_grant <= '0;
					last_idx <= grant_idx;
					state <= arb_idle;
				end
			end
			arb_nak: begin
				if (tx_char_ready) begin
					if (nak_pos == 2'd2) begin
						nak_pending <= 1'b0;
						state <= arb_idle;
					end else begin
						nak_pos <= nak_pos + 2'd1;
					end
				end
			end
			default: state <= arb_idle;
		endcase
		// New request wins over the clear
		if (generate_nak)
			nak_pending <= 1'b1;
	end
end

// A second NAK before the first drains overwrites the event id
always_ff @(posedge clk) begin
	if (generate_nak)
		nak_evt_q <= nak_evt;
end

endmodule

// File: hw/ice_bus.sv
module ice_bus import ice_pkg::*; (
	input logic clk,
	input logic reset,

	// Host side
	input char_t rx_char,
	input logic rx_char_valid,
	input logic tx_char_ready,
	output char_t tx_char,
	output logic tx_char_valid
);

// Master bus
char_t ma_addr;
char_t ma_evt;
char_t ma_len;
char_t ma_data;
logic ma_data_valid;
logic ma_frame_valid;

// Unknown address path
logic generate_nak;
char_t nak_evt;

// Reply bus, one slice per node
wire node_sel_t sl_request;
wire tagged_char_t sl_data [num_nodes];
node_sel_t sl_grant;
node_sel_t sl_next;

// Host frame parser
ice_bus_controller u_ctrl (
	.clk(clk),
	.reset(reset),
	.rx_char(rx_char),
	.rx_char_valid(rx_char_valid),
	.ma_addr(ma_addr),
	.ma_evt(ma_evt),
	.ma_len(ma_len),
	.ma_data(ma_data),
	.ma_data_valid(ma_data_valid),
	.ma_frame_valid(ma_frame_valid),
	.generate_nak(generate_nak),
	.nak_evt(nak_evt)
);

// Node address equals its slot
for (genvar i = 0; i < num_nodes; i++) begin : g_node
	register_node #(.node_id(i)) u_node (
		.clk(clk),
		.reset(reset),
		.ma_addr(ma_addr),
		.ma_evt(ma_evt),
		.ma_len(ma_len),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.sl_grant(sl_grant[i]),
		.sl_next(sl_next[i]),
		.sl_request(sl_request[i]),
		.sl_data(sl_data[i])
	);
end

// Drains replies and NAKs to the transmitter
response_arbiter u_arb (
	.clk(clk),
	.reset(reset),
	.sl_request(sl_request),
	.sl_data(sl_data),
	.sl_grant(sl_grant),
	.sl_next(sl_next),
	.generate_nak(generate_nak),
	.nak_evt(nak_evt),
	.tx_char_ready(tx_char_ready),
	.tx_char(tx_char),
	.tx_char_valid(tx_char_valid)
);

endmodule

// File: tb/ice_bus_tb_model.svh
// Register contents the host expects, per node
char_t model_regs [num_nodes][num_regs];

// Everything is zero out of reset
function automatic void model_clear();
	for (int n = 0; n < num_nodes; n++)
		for (int r = 0; r < num_regs; r++)
			model_regs[n][r] = 8'h00;
endfunction

// Fresh event id for every host frame
function automatic char_t take_evt();
	char_t e;
	e = evt_seq;
	evt_seq = evt_seq + 8'd1;
	return e;
endfunction

// Board to host frame: address, event, length, payload
// Payload bytes beyond the length stay zero, same as the monitor
function automatic frame_t reply_frame(input char_t addr, input char_t evt, input char_t len,
	input char_t p0, input char_t p1);
	frame_t f;
	f = '0;
	f[7:0] = addr;
	f[15:8] = evt;
	f[23:16] = len;
	if (len >= 8'd1)
		f[31:24] = p0;
	if (len >= 8'd2)
		f[39:32] = p1;
	return f;
endfunction

// One host frame, a character every other cycle
task automatic send_frame(input char_t addr, input char_t evt, input char_t len,
	input char_t p0, input char_t p1, input char_t p2);
	char_t bytes [6];
	bytes[0] = addr;
	bytes[1] = evt;
	bytes[2] = len;
	bytes[3] = p0;
	bytes[4] = p1;
	bytes[5] = p2;
	for (int k = 0; k < 3 + int'(len) && k < 6; k++) begin
		@(posedge clk);
		#2;
		rx_char = bytes[k];
		rx_char_valid = 1'b1;
		@(posedge clk);
		#2;
		rx_char_valid = 1'b0;
	end
endtask

// Next complete frame from the monitor, or nothing after a long wait
task automatic collect_frame(output frame_t f, output bit arrived);
	int waited;
	waited = 0;
	while (frames.size() == 0 && waited < 400) begin
		@(posedge clk);
		waited++;
	end
	arrived = (frames.size() != 0);
	f = '0;
	if (arrived)
		f = frames.pop_front();
endtask

// File: tb/ice_bus_tb.sv
module ice_bus_tb import ice_pkg::*; ();

// Reply frame, byte k sits at bits 8k+7 down to 8k
typedef logic [39:0] frame_t;

// 16 + 28 + 3 + 8 + 4 + 40 frames over the six tests
localparam int frames_total = 99;
localparam int cycle_limit = frames_total * 64 + 500;

logic clk = 1'b0;
logic reset;
char_t rx_char;
logic rx_char_valid;
logic tx_char_ready = 1'b0;
char_t tx_char;
logic tx_char_valid;

// Transmitter model
logic hold_low = 1'b0;
logic random_gaps = 1'b0;
logic taken_now = 1'b0;
int gap_left = 0;

// Response monitor
frame_t frames [$];
frame_t cur_frame = '0;
int cur_cnt = 0;
int bytes_seen = 0;

// Run bookkeeping
int cycle_count = 0;
int test_errors = 0;
int tests_passed = 0;
int tests_failed = 0;
string test_name = "";
char_t evt_seq = 8'h10;

ice_bus i_ice_bus (
	.clk(clk),
	.reset(reset),
	.rx_char(rx_char),
	.rx_char_valid(rx_char_valid),
	.tx_char_ready(tx_char_ready),
	.tx_char(tx_char),
	.tx_char_valid(tx_char_valid)
);

`include "ice_bus_tb_model.svh"

always #10 clk = ~clk;

// Ready drops for 0 to 7 cycles after each byte in random mode
always @(posedge clk) begin
	#2;
	if (taken_now) begin
		gap_left = random_gaps ? int'($urandom_range(7, 0)) : 0;
		taken_now = 1'b0;
	end else if (gap_left > 0) begin
		gap_left = gap_left - 1;
	end
	tx_char_ready = !reset && !hold_low && (gap_left == 0);
end

// Sampled mid cycle, the byte is taken at the next rising edge
always @(negedge clk) begin
	if (!reset && tx_char_valid) begin
		assert (tx_char_ready) else begin
			$display("%s: tx_char_valid rose while the transmitter was not ready", test_name);
			test_errors++;
		end
		taken_now = 1'b1;
		bytes_seen++;
		if (cur_cnt < 5)
			cur_frame[8*cur_cnt +: 8] = tx_char;
		cur_cnt++;
		// Length byte says where the frame ends
		if (cur_cnt >= 3 && cur_cnt == 3 + int'(cur_frame[23:16])) begin
			frames.push_back(cur_frame);
			cur_frame = '0;
			cur_cnt = 0;
		end
	end
end

always @(posedge clk) begin
	cycle_count++;
	if (cycle_count >= cycle_limit) begin
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("STATUS: FAIL");
		$finish;
	end
end

task automatic start_test(input string name);
	test_name = name;
	test_errors = 0;
endtask

// Quiet period, then nothing may be left over
task automatic finish_test(input int num);
	repeat (20) @(posedge clk);
	assert (frames.size() == 0) else begin
		$display("%s: %0d reply frame(s) arrived that nobody asked for",
			test_name, frames.size());
		test_errors++;
	end
	frames.delete();
	if (test_errors == 0)
		tests_passed++;
	else
		tests_failed++;
	$display("test %0d %s: %s (%0d errors)", num, test_name,
		(test_errors == 0) ? "passed" : "failed", test_errors);
endtask

task automatic expect_reply(input frame_t exp);
	frame_t got;
	bit arrived;
	collect_frame(got, arrived);
	assert (arrived) else begin
		$display("%s: an expected reply frame never arrived", test_name);
		test_errors++;
	end
	if (arrived) begin
		assert (got == exp) else begin
			$display("error: %s expected %h actual %h", test_name, exp, got);
			test_errors++;
		end
	end
endtask

task automatic write_reg(input int node, input int idx, input char_t value);
	char_t evt;
	evt = take_evt();
	send_frame(char_t'(node), evt, 8'd3, op_write, char_t'(idx), value);
	model_regs[node][idx] = value;
	expect_reply(reply_frame(char_t'(node), evt, 8'd1, status_ack, 8'h00));
endtask

task automatic read_reg(input int node, input int idx);
	char_t evt;
	evt = take_evt();
	send_frame(char_t'(node), evt, 8'd2, op_read, char_t'(idx), 8'h00);
	expect_reply(reply_frame(char_t'(node), evt, 8'd2, status_ack, model_regs[node][idx]));
endtask

// Node must answer with a single nak byte
task automatic send_malformed(input int node, input char_t len, input char_t p0,
	input char_t p1, input char_t p2);
	char_t evt;
	evt = take_evt();
	send_frame(char_t'(node), evt, len, p0, p1, p2);
	expect_reply(reply_frame(char_t'(node), evt, 8'd1, status_nak, 8'h00));
endtask

// Controller NAK carries no payload
task automatic send_unknown(input char_t addr, input char_t len);
	char_t evt;
	evt = take_evt();
	send_frame(addr, evt, len, op_write, 8'd1, 8'h5A);
	expect_reply(reply_frame(nak_addr, evt, 8'd0, 8'h00, 8'h00));
endtask

initial begin
	frame_t exp_stalled [num_nodes];
	bit seen [num_nodes];
	frame_t got;
	bit arrived;
	char_t evt;
	int node;
	int idx;
	int bytes_before;
	void'($urandom(32'h6a5c_9958));
	reset = 1'b1;
	rx_char = 8'h00;
	rx_char_valid = 1'b0;
	model_clear();
	repeat (2) @(posedge clk);
	#2;
	reset = 1'b0;

	// Idle after reset, then every register reads back zero
	start_test("reset_reads");
	repeat (10) @(posedge clk);
	assert (bytes_seen == 0) else begin
		$display("%s: the board transmitted before any command", test_name);
		test_errors++;
	end
	for (int n = 0; n < num_nodes; n++)
		for (int r = 0; r < num_regs; r++)
			read_reg(n, r);
	finish_test(1);

	start_test("write_read");
	for (int n = 0; n < num_nodes; n++) begin
		for (int k = 0; k < 3; k++)
			write_reg(n, $urandom_range(num_regs - 1, 0), char_t'($urandom()));
		for (int r = 0; r < num_regs; r++)
			read_reg(n, r);
	end
	finish_test(2);

	// Address 4 is one past the last node
	start_test("unknown_addr");
	send_unknown(8'd4, 8'd2);
	send_unknown(nak_addr, 8'd3);
	read_reg(1, 2);
	finish_test(3);

	start_test("malformed");
	// Bad opcode
	send_malformed(2, 8'd2, 8'h33, 8'd0, 8'd0);
	// Index out of range
	send_malformed(2, 8'd3, op_write, 8'd4, 8'hA5);
	// Write one byte short
	send_malformed(2, 8'd2, op_write, 8'd1, 8'd0);
	// Empty payload
	send_malformed(2, 8'd0, 8'd0, 8'd0, 8'd0);
	for (int r = 0; r < num_regs; r++)
		read_reg(2, r);
	finish_test(4);

	// All four nodes queue replies behind a stalled transmitter
	start_test("stalled_tx");
	hold_low = 1'b1;
	bytes_before = bytes_seen;
	for (int n = 0; n < num_nodes; n++) begin
		evt = take_evt();
		send_frame(char_t'(n), evt, 8'd2, op_read, char_t'(n), 8'd0);
		exp_stalled[n] = reply_frame(char_t'(n), evt, 8'd2, status_ack, model_regs[n][n]);
		seen[n] = 1'b0;
	end
	repeat (20) @(posedge clk);
	assert (bytes_seen == bytes_before) else begin
		$display("%s: bytes went out while ready was held low", test_name);
		test_errors++;
	end
	hold_low = 1'b0;
	for (int k = 0; k < num_nodes; k++) begin
		collect_frame(got, arrived);
		assert (arrived) else begin
			$display("%s: only %0d of %0d replies arrived", test_name, k, num_nodes);
			test_errors++;
		end
		if (arrived) begin
			node = int'(got[7:0]);
			assert (node < num_nodes) else begin
				$display("%s: a reply came from address %0d with no node", test_name, node);
				test_errors++;
			end
			if (node < num_nodes) begin
				assert (!seen[node]) else begin
					$display("%s: node %0d replied more than once", test_name, node);
					test_errors++;
				end
				seen[node] = 1'b1;
				assert (got == exp_stalled[node]) else begin
					$display("error: %s expected %h actual %h",
						test_name, exp_stalled[node], got);
					test_errors++;
				end
			end
		end
	end
	finish_test(5);

	// Mixed traffic against the model, transmitter pacing at random
	start_test("random_traffic");
	random_gaps = 1'b1;
	for (int k = 0; k < 40; k++) begin
		node = $urandom_range(num_nodes - 1, 0);
		idx = $urandom_range(num_regs - 1, 0);
		if ($urandom_range(1, 0) == 1)
			write_reg(node, idx, char_t'($urandom()));
		else
			read_reg(node, idx);
	end
	random_gaps = 1'b0;
	finish_test(6);

	$display("tests passed %0d failed %0d", tests_passed, tests_failed);
	if (tests_failed == 0)
		$display("STATUS: PASS");
	else
		$display("STATUS: FAIL");
	$finish;
end

endmodule

// File: list.f
+incdir+tb
hw/ice_pkg.sv
hw/ice_bus_controller.sv
hw/register_node.sv
hw/response_arbiter.sv
hw/ice_bus.sv
tb/ice_bus_tb.sv
